//--- verilog.f
common/rx_cfg_pkg.sv
common/rx_types_pkg.sv
hdl/rx_lane_ctrl.sv
hdl/lane_deser.sv
lane_merge/flit_fifo.sv
lane_merge/lane_merge.sv
hdl/serial_rx_top.sv
verif/serial_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile the serial receiver with its testbench and run it with Verilator.
# The run counts as passed only if the pass message shows up in the output.

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module serial_rx_tb \
    -o serial_rx_sim \
    && ./obj_dir/serial_rx_sim | tee /dev/stderr | grep -q "Simulation passed" \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }

//--- verif/serial_rx_tb.sv
// Serial receiver testbench
// Drives four serial lanes and the command port, models the
// downstream credit return and checks flits, locks and overflow

`timescale 1ns/1ps
`default_nettype none

module serial_rx_tb
    import rx_cfg_pkg::*, rx_types_pkg::*;
();

    logic                 clk = 1'b0;
    logic                 rst_n = 1'b0;
    logic [NUM_LANES-1:0] serial_in = '0;
    rx_cmd_t              cmd = '0;
    logic                 cmd_valid = 1'b0;
    logic                 credit_in = 1'b0;
    rx_flit_t             out_flit;
    logic                 out_valid;
    logic [NUM_LANES-1:0] lane_locked;
    logic                 overflow;

    logic [BYTE_W-1:0]    exp_q [NUM_LANES][$];    // Expected bytes per lane
    logic                 bits_q [NUM_LANES][$];   // Pending serial bits
    logic [NUM_LANES-1:0] quiet = '0;              // Lanes that must stay unlocked
    logic [NUM_LANES-1:0] locked_seen = '0;
    integer               seed = 28;
    int                   errors = 0;
    int                   err_start = 0;
    int                   pass_cnt = 0;
    int                   fail_cnt = 0;
    int                   outstanding = 0;         // Flits seen minus credits returned
    int                   owed = 0;                // Credits not yet driven
    bit                   hold_credits = 1'b0;
    bit                   ovf_allowed = 1'b0;

    always #5 clk = ~clk;                          // 10 ns period

    serial_rx_top serial_rx_top_i (
        .clk (clk), .rst_n (rst_n), .serial_in (serial_in), .cmd (cmd),
        .cmd_valid (cmd_valid), .out_flit (out_flit), .out_valid (out_valid),
        .credit_in (credit_in), .lane_locked (lane_locked), .overflow (overflow)
    );

    // ========================================
    // Credit model and flit checker
    // ========================================
    always @(posedge clk) begin
        if (!rst_n) begin
            owed        = 0;
            outstanding = 0;
            credit_in  <= 1'b0;
        end else begin
            outstanding = outstanding + int'(out_valid) - int'(credit_in);
            if (out_valid) owed++;
            if (owed > 0 && !hold_credits) begin
                credit_in <= 1'b1;                 // One credit per flit on the next cycle
                owed--;
            end else begin
                credit_in <= 1'b0;
            end
            locked_seen |= lane_locked;
        end
    end

    always @(posedge clk) begin
        if (rst_n && out_valid) begin
            assert (exp_q[out_flit.lane].size() > 0) else begin
                $display("FAIL %0t: unexpected flit %h on lane %0d", $time,
                         out_flit.data, out_flit.lane);
                errors++;
            end
            if (exp_q[out_flit.lane].size() > 0) begin
                assert (out_flit.data == exp_q[out_flit.lane][0]) else begin
                    $display("FAIL %0t: lane %0d flit %h, expected %h", $time,
                             out_flit.lane, out_flit.data, exp_q[out_flit.lane][0]);
                    errors++;
                end
                void'(exp_q[out_flit.lane].pop_front());
            end
        end
    end

    credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding <= CREDIT_MAX)
        else begin
            $display("FAIL %0t: %0d flits outstanding", $time, outstanding);
            errors++;
        end
    credit_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (hold_credits && outstanding == CREDIT_MAX) |-> !out_valid)
        else begin
            $display("FAIL %0t: flit sent without credit", $time);
            errors++;
        end
    lock_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (quiet & lane_locked) == '0)
        else begin
            $display("FAIL %0t: lane locked %b", $time, lane_locked);
            errors++;
        end
    ovf_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        $past(overflow) |-> overflow)
        else begin
            $display("FAIL %0t: overflow cleared", $time);
            errors++;
        end
    ovf_none: assert property (@(posedge clk) disable iff (!rst_n)
        !ovf_allowed |-> !overflow)
        else begin
            $display("FAIL %0t: overflow without back-pressure", $time);
            errors++;
        end

    // ========================================
    // Stimulus helpers
    // ========================================
    task automatic abort_timeout(input string what);
        $display("Timeout while waiting for %s at %0t", what, $time);
        $display("Simulation failed");
        $finish;
    endtask

    // Garbage must not hit the sync pattern before the real sync
    function automatic bit hunt_clean(input int lane, input bit with_sync);
        logic [BYTE_W-1:0] win;
        win = '0;
        for (int i = 0; i < bits_q[lane].size(); i++) begin
            win = {bits_q[lane][i], win[BYTE_W-1:1]};
            if (win == SYNC_BYTE && !(with_sync && i == bits_q[lane].size() - 1))
                return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic build_lane(input int lane, input int n_bytes, input int garbage_max,
                              input bit with_sync, input bit track);
        int rnd;
        int glen;
        do begin
            bits_q[lane].delete();
            rnd  = $random(seed);
            glen = (garbage_max > 0) ? (rnd & 32'h7fff_ffff) % garbage_max : 0;
            for (int i = 0; i < glen; i++) begin
                rnd = $random(seed);
                bits_q[lane].push_back(rnd[0]);
            end
            if (with_sync)
                for (int i = 0; i < BYTE_W; i++) bits_q[lane].push_back(SYNC_BYTE[i]);
        end while (!hunt_clean(lane, with_sync));
        repeat (n_bytes) begin
            do rnd = $random(seed); while (rnd[BYTE_W-1:0] == SYNC_BYTE);  // Sync is swallowed
            for (int i = 0; i < BYTE_W; i++) bits_q[lane].push_back(rnd[i]);  // LSB first
            if (track) exp_q[lane].push_back(rnd[BYTE_W-1:0]);
        end
    endtask

    task automatic send_cmd(input lane_cmd_e op, input logic [NUM_LANES-1:0] mask);
        @(posedge clk);
        cmd.op    <= op;
        cmd.mask  <= mask;
        cmd_valid <= 1'b1;
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    // Streams end together and a command then stops the locked lanes
    task automatic drive_streams(input lane_cmd_e end_op, input logic [NUM_LANES-1:0] end_mask);
        int                   maxlen;
        logic [NUM_LANES-1:0] vec;
        maxlen = 0;
        for (int l = 0; l < NUM_LANES; l++)
            if (bits_q[l].size() > maxlen) maxlen = bits_q[l].size();
        for (int l = 0; l < NUM_LANES; l++) begin
            while (bits_q[l].size() < maxlen + 8) bits_q[l].push_front(1'b0);  // Idle lead-in
        end
        for (int c = 0; c < maxlen + 8; c++) begin
            for (int l = 0; l < NUM_LANES; l++) vec[l] = bits_q[l].pop_front();
            @(posedge clk);
            serial_in <= vec;
        end
        @(posedge clk);
        serial_in <= '0;
        cmd.op    <= end_op;
        cmd.mask  <= end_mask;
        cmd_valid <= 1'b1;                         // Before idle zeros frame a byte
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    function automatic int queued();
        int n;
        n = 0;
        for (int l = 0; l < NUM_LANES; l++) n += exp_q[l].size();
        return n;
    endfunction

    task automatic wait_drain();
        int n;
        n = 0;
        while (queued() != 0 && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (queued() != 0) abort_timeout("expected flits to arrive");
    endtask

    task automatic wait_unlocked();
        int n;
        n = 0;
        while (lane_locked != '0 && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (lane_locked != '0) abort_timeout("lanes to drop lock");
    endtask

    task automatic apply_reset();
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (int l = 0; l < NUM_LANES; l++) exp_q[l].delete();
    endtask

    task automatic start_test();
        @(negedge clk);
        err_start   = errors;
        locked_seen = '0;
    endtask

    task automatic end_test(input string name);
        @(negedge clk);
        if (errors == err_start) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed", name);
        end
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        int n;
        apply_reset();

        start_test();                              // Aligned lanes without garbage
        send_cmd(CMD_ENABLE, 4'hF);
        for (int l = 0; l < NUM_LANES; l++) build_lane(l, 6, 0, 1'b1, 1'b1);
        drive_streams(CMD_DISABLE, 4'hF);
        wait_drain();
        assert (locked_seen == 4'hF) else begin
            $display("FAIL %0t: locks seen %b", $time, locked_seen);
            errors++;
        end
        end_test("lock and byte order");

        start_test();                              // Random offsets per lane
        send_cmd(CMD_ENABLE, 4'hF);
        for (int l = 0; l < NUM_LANES; l++) build_lane(l, 6, 24, 1'b1, 1'b1);
        drive_streams(CMD_DISABLE, 4'hF);
        wait_drain();
        assert (locked_seen == 4'hF) else begin
            $display("FAIL %0t: locks seen %b", $time, locked_seen);
            errors++;
        end
        end_test("bit slip");

        start_test();
        hold_credits = 1'b1;
        send_cmd(CMD_ENABLE, 4'hF);
        for (int l = 0; l < NUM_LANES; l++) build_lane(l, 3, 16, 1'b1, 1'b1);
        drive_streams(CMD_DISABLE, 4'hF);
        n = 0;
        while (outstanding != CREDIT_MAX && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (outstanding != CREDIT_MAX) abort_timeout("credits to run out");
        repeat (32) @(negedge clk);                // Stall window
        assert (queued() == NUM_LANES * 3 - CREDIT_MAX) else begin
            $display("FAIL %0t: %0d flits still queued", $time, queued());
            errors++;
        end
        hold_credits = 1'b0;
        wait_drain();
        end_test("credits");

        start_test();
        quiet = 4'b0100;                           // Lane 2 stays disabled
        send_cmd(CMD_ENABLE, 4'b1011);
        for (int l = 0; l < NUM_LANES; l++) build_lane(l, 4, 16, 1'b1, l != 2);
        drive_streams(CMD_REALIGN, 4'hF);
        wait_drain();
        wait_unlocked();
        quiet = 4'b0110;                           // Lane 1 sees no sync
        build_lane(0, 4, 16, 1'b1, 1'b1);
        build_lane(1, 0, 24, 1'b0, 1'b0);
        build_lane(2, 4, 16, 1'b1, 1'b0);
        build_lane(3, 4, 16, 1'b1, 1'b1);
        drive_streams(CMD_REALIGN, 4'hF);
        wait_drain();
        wait_unlocked();
        quiet = 4'b0100;
        build_lane(1, 4, 16, 1'b1, 1'b1);          // Resume after realign
        drive_streams(CMD_DISABLE, 4'hF);
        wait_drain();
        assert (locked_seen == 4'b1011) else begin
            $display("FAIL %0t: locks seen %b", $time, locked_seen);
            errors++;
        end
        quiet = '0;
        end_test("commands");

        start_test();
        hold_credits = 1'b1;
        ovf_allowed  = 1'b1;
        send_cmd(CMD_ENABLE, 4'hF);
        for (int l = 0; l < NUM_LANES; l++) build_lane(l, 8, 0, 1'b1, 1'b1);
        drive_streams(CMD_DISABLE, 4'hF);
        n = 0;
        while (!overflow && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!overflow) abort_timeout("overflow to rise");
        repeat (16) @(negedge clk);                // Overflow has to hold here
        apply_reset();
        hold_credits = 1'b0;
        ovf_allowed  = 1'b0;
        @(negedge clk);
        assert (!overflow && lane_locked == '0 && !out_valid) else begin
            $display("FAIL %0t: state after reset not cleared", $time);
            errors++;
        end
        end_test("overflow");

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 pass_cnt, fail_cnt, errors);
        if (fail_cnt == 0 && errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule : serial_rx_tb

`default_nettype wire

//--- hdl/serial_rx_top.sv
// Four lane serial receiver top
// Command decoder, one deserializer per lane and the lane merge

`timescale 1ns/1ps
`default_nettype none

module serial_rx_top
    import rx_cfg_pkg::*, rx_types_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire [NUM_LANES-1:0]  serial_in,     // One bit per lane
    input  rx_cmd_t              cmd,
    input  wire                  cmd_valid,
    output rx_flit_t             out_flit,
    output logic                 out_valid,
    input  wire                  credit_in,
    output logic [NUM_LANES-1:0] lane_locked,
    output logic                 overflow
);

    lane_ctl_t  lane_ctl  [NUM_LANES];
    lane_byte_t lane_byte [NUM_LANES];

    rx_lane_ctrl u_lane_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .lane_ctl  (lane_ctl)
    );

    // ========================================
    // Lane deserializers
    // ========================================
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        lane_deser u_lane_deser (
            .clk       (clk),
            .rst_n     (rst_n),
            .ctl       (lane_ctl[g]),
            .serial_in (serial_in[g]),
            .lane_byte (lane_byte[g]),
            .locked    (lane_locked[g])
        );
    end

    lane_merge u_lane_merge (
        .clk       (clk),
        .rst_n     (rst_n),
        .lane_byte (lane_byte),
        .out_flit  (out_flit),
        .out_valid (out_valid),
        .credit_in (credit_in),
        .overflow  (overflow)
    );

endmodule : serial_rx_top

`default_nettype wire

//--- lane_merge/lane_merge.sv
// Lane merge
// Holds one byte per lane, drains them round robin into a flit
// FIFO and sends flits downstream under credit flow control

`timescale 1ns/1ps
`default_nettype none

module lane_merge
    import rx_cfg_pkg::*, rx_types_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  lane_byte_t lane_byte [NUM_LANES],   // Must be taken on valid
    output rx_flit_t   out_flit,
    output logic       out_valid,
    input  wire        credit_in,               // One credit per pulse
    output logic       overflow                 // Sticky until reset
);

    // ========================================
    // Holding registers and round robin
    // ========================================
    rx_flit_t             hold_flit [NUM_LANES];
    logic [NUM_LANES-1:0] hold_valid;
    logic [LANE_ID_W-1:0] rr_ptr;
    logic [NUM_LANES-1:0] drain;                // Lane moved into FIFO
    logic                 fifo_push;
    logic                 fifo_pop;
    logic                 fifo_empty;
    logic                 fifo_full;
    rx_flit_t             fifo_head;
    logic [CREDIT_W-1:0]  credit_cnt;

    assign fifo_push = hold_valid[rr_ptr] && !fifo_full;
    assign drain     = fifo_push ? (NUM_LANES'(1) << rr_ptr) : '0;
    assign fifo_pop  = !fifo_empty && (credit_cnt != '0);

    // Capture with lane tag, refill allowed in the drain cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (lane_byte[i].valid && (!hold_valid[i] || drain[i])) begin
                hold_flit[i].lane <= LANE_ID_W'(i);
                hold_flit[i].data <= lane_byte[i].data;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_valid <= '0;
            rr_ptr     <= '0;
            overflow   <= 1'b0;
        end else begin
            rr_ptr <= rr_ptr + 1'b1;            // Visit every lane in turn
            for (int i = 0; i < NUM_LANES; i++) begin
                if (lane_byte[i].valid) begin
                    if (hold_valid[i] && !drain[i])
                        overflow <= 1'b1;       // Byte lost
                    else
                        hold_valid[i] <= 1'b1;
                end else if (drain[i]) begin
                    hold_valid[i] <= 1'b0;
                end
            end
        end
    end

    flit_fifo u_flit_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (fifo_push),
        .push_flit (hold_flit[rr_ptr]),
        .pop       (fifo_pop),
        .pop_flit  (fifo_head),
        .empty     (fifo_empty),
        .full      (fifo_full)
    );

    // ========================================
    // Credit output
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= CREDIT_W'(CREDIT_MAX);
            out_valid  <= 1'b0;
        end else begin
            out_valid <= fifo_pop;
            case ({fifo_pop, credit_in})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;  // Spend
                2'b01:   credit_cnt <= credit_cnt + 1'b1;  // Returned
                default: ;                                 // Net zero
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_pop)
            out_flit <= fifo_head;
    end

endmodule : lane_merge

`default_nettype wire

//--- lane_merge/flit_fifo.sv
// Tagged flit FIFO
// Circular buffer between lane collection and credit output

`timescale 1ns/1ps
`default_nettype none

module flit_fifo
    import rx_cfg_pkg::*, rx_types_pkg::*;
(
    input  wire      clk,
    input  wire      rst_n,
    input  wire      push,                      // Never while full
    input  rx_flit_t push_flit,
    input  wire      pop,                       // Never while empty
    output rx_flit_t pop_flit,
    output logic     empty,
    output logic     full
);

    rx_flit_t              mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;               // Occupancy, 0 to FIFO_DEPTH

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= push_flit;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // Power of two depth, wraps
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                      // Both or neither
            endcase
        end
    end

    assign pop_flit = mem[rd_ptr];              // Head, read ahead
    assign empty    = (count == '0);
    assign full     = (count == (FIFO_PTR_W+1)'(FIFO_DEPTH));

endmodule : flit_fifo

`default_nettype wire

//--- hdl/lane_deser.sv
// Single lane deserializer
// Hunts for the sync byte at any bit offset, then frames the
// following bits into bytes, LSB first

`timescale 1ns/1ps
`default_nettype none

module lane_deser
    import rx_cfg_pkg::*, rx_types_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  lane_ctl_t  ctl,                     // Enable and realign
    input  wire        serial_in,               // One bit per clock
    output lane_byte_t lane_byte,
    output logic       locked
);

    // ========================================
    // Window and framing state
    // ========================================
    lane_state_e       state;
    logic [BYTE_W-1:0] window;                  // Newest bit at the top
    logic [2:0]        phase;                   // Data bits in window, minus one
    logic              byte_valid;
    logic [BYTE_W-1:0] byte_data;
    logic              byte_done;

    // Full byte sits in the window this cycle
    assign byte_done = (state == ST_LOCKED) && (phase == 3'd7);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_HUNT;
            window     <= '0;
            phase      <= '0;
            byte_valid <= 1'b0;
        end else if (!ctl.enable) begin
            // Idle lane, flush everything
            state      <= ST_HUNT;
            window     <= '0;
            phase      <= '0;
            byte_valid <= 1'b0;
        end else begin
            window     <= {serial_in, window[BYTE_W-1:1]};  // LSB arrives first
            byte_valid <= 1'b0;
            if (ctl.realign) begin
                state <= ST_HUNT;               // Drop lock at once
                phase <= '0;
            end else begin
                case (state)
                    ST_HUNT: begin
                        phase <= '0;
                        // Compare at every bit offset
                        if (window == SYNC_BYTE)
                            state <= ST_LOCKED;
                    end
                    ST_LOCKED: begin
                        phase <= phase + 3'd1;  // Wraps on each boundary
                        if (phase == 3'd7)
                            byte_valid <= (window != SYNC_BYTE);  // Swallow sync
                    end
                    default: state <= ST_HUNT;
                endcase
            end
        end
    end

    // Byte payload
    always_ff @(posedge clk) begin
        if (byte_done)
            byte_data <= window;
    end

    assign lane_byte.valid = byte_valid;
    assign lane_byte.data  = byte_data;
    assign locked          = (state == ST_LOCKED);

endmodule : lane_deser

`default_nettype wire

//--- hdl/rx_lane_ctrl.sv
// Lane command decoder
// Keeps the per-lane enable register and turns masked commands
// into enable updates and single cycle realign pulses

`timescale 1ns/1ps
`default_nettype none

module rx_lane_ctrl
    import rx_cfg_pkg::*, rx_types_pkg::*;
(
    input  wire                clk,
    input  wire                rst_n,
    input  rx_cmd_t            cmd,             // Qualified by cmd_valid
    input  wire                cmd_valid,
    output lane_ctl_t          lane_ctl [NUM_LANES]
);

    logic [NUM_LANES-1:0] enable_q;             // Sticky lane enables
    logic [NUM_LANES-1:0] realign_q;            // One cycle pulses

    // Command takes effect one cycle after cmd_valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable_q  <= '0;
            realign_q <= '0;
        end else begin
            realign_q <= '0;                    // Pulse default
            if (cmd_valid) begin
                case (cmd.op)
                    CMD_ENABLE:  enable_q  <= enable_q | cmd.mask;
                    CMD_DISABLE: enable_q  <= enable_q & ~cmd.mask;
                    CMD_REALIGN: realign_q <= cmd.mask;
                    default:     ;              // NOP, nothing to do
                endcase
            end
        end
    end

    // Fan out into per-lane control words
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_ctl[i].enable  = enable_q[i];
            lane_ctl[i].realign = realign_q[i];
        end
    end

endmodule : rx_lane_ctrl

`default_nettype wire

//--- common/rx_types_pkg.sv
// Serial receiver types
// Command, lane control, lane byte and output flit formats
// shared by lane control, lanes, merge and top

`default_nettype none

package rx_types_pkg;

    import rx_cfg_pkg::*;

    // ========================================
    // Lane command interface
    // ========================================
    typedef enum logic [1:0] {
        CMD_NOP     = 2'd0,                 // No effect
        CMD_ENABLE  = 2'd1,                 // Set enable on masked lanes
        CMD_DISABLE = 2'd2,                 // Clear enable on masked lanes
        CMD_REALIGN = 2'd3                  // Back to hunt on masked lanes
    } lane_cmd_e;

    typedef struct packed {
        lane_cmd_e            op;
        logic [NUM_LANES-1:0] mask;         // One bit per lane
    } rx_cmd_t;

    // Per-lane control from the command decoder
    typedef struct packed {
        logic enable;
        logic realign;                      // Single cycle pulse
    } lane_ctl_t;

    // ========================================
    // Lane datapath
    // ========================================
    typedef enum logic [0:0] {
        ST_HUNT   = 1'b0,                   // Searching for sync
        ST_LOCKED = 1'b1                    // Byte boundary known
    } lane_state_e;

    typedef struct packed {
        logic              valid;           // One cycle per byte, no handshake
        logic [BYTE_W-1:0] data;
    } lane_byte_t;

    typedef struct packed {
        logic [LANE_ID_W-1:0] lane;         // Source lane tag
        logic [BYTE_W-1:0]    data;
    } rx_flit_t;

endpackage : rx_types_pkg

`default_nettype wire

//--- common/rx_cfg_pkg.sv
// Serial receiver configuration
// Lane count, byte framing, sync pattern and buffer sizing

`default_nettype none

package rx_cfg_pkg;

    // ========================================
    // Lane geometry
    // ========================================
    localparam int NUM_LANES = 4;           // Serial lanes
    localparam int LANE_ID_W = 2;           // Lane number width
    localparam int BYTE_W    = 8;           // Bits per byte

    // Alignment pattern, sent LSB first
    localparam logic [BYTE_W-1:0] SYNC_BYTE = 8'hBC;

    // ========================================
    // Buffering and flow control
    // ========================================
    localparam int FIFO_DEPTH = 8;          // Flit FIFO entries
    localparam int FIFO_PTR_W = 3;          // Index into FIFO_DEPTH entries
    localparam int CREDIT_MAX = 4;          // Downstream buffer, in flits
    localparam int CREDIT_W   = 3;          // Credit counter width

endpackage : rx_cfg_pkg

`default_nettype wire
